// File: isaPkg.sv
`default_nettype none

package isaPkg;

	localparam int wordWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int shamtWidth = 5;
	localparam int immWidth = 16;

	// primary opcode, bits 31:26
	typedef enum logic [5:0] {
		ARIT = 6'b000000, // R-type, see funct
		ADDI = 6'b001000,
		ADDIU = 6'b001001
	} opcode_t;

	// R-type funct, bits 5:0
	typedef enum logic [5:0] {
		SLL = 6'b000000,
		SRL = 6'b000010,
		SRA = 6'b000011,
		SLLV = 6'b000100,
		SRAV = 6'b000111,
		JR = 6'b001000,
		ADD = 6'b100000,
		SUB = 6'b100010,
		AND = 6'b100100,
		SLT = 6'b101010
	} funct_t;

endpackage

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	typedef enum logic [2:0] {
		stFetch,
		stDecode,
		stAluExec,
		stAluWrite,
		stShiftLoad,
		stShiftRun,
		stShiftWrite,
		stJump
	} state_t;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluSlt // signed compare
	} aluOp_t;

	typedef enum logic {
		srcReg, // operand register B
		srcImm // sign-extended immediate
	} srcB_t;

	typedef enum logic [2:0] {
		shiftHold,
		shiftLoad,
		shiftLeft,
		shiftRightLogic,
		shiftRightArith
	} shiftOp_t;

	typedef enum logic {
		amtShamt,
		amtReg // low bits of A
	} amtSrc_t;

	typedef enum logic {
		dstRd,
		dstRt
	} regDst_t;

	typedef enum logic {
		wbAlu,
		wbShift
	} wbSrc_t;

	typedef enum logic {
		pcSeq,
		pcReg
	} pcSrc_t;

endpackage

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
	input wire logic clk,
	input wire logic reset,
	input wire isaPkg::opcode_t opcode,
	input wire isaPkg::funct_t funct,
	output logic irLoad,
	output logic pcLoad,
	output logic operandLoad,
	output logic regWrite,
	output logic instrRead,
	output logic aluOutLoad,
	output ctrlPkg::regDst_t regDst,
	output ctrlPkg::wbSrc_t wbSrc,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::srcB_t srcB,
	output ctrlPkg::shiftOp_t shiftOp,
	output ctrlPkg::amtSrc_t amtSrc,
	output ctrlPkg::pcSrc_t pcSrc
);

	ctrlPkg::state_t state;
	ctrlPkg::shiftOp_t shiftDir; // direction picked at decode

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrlPkg::stFetch;
			aluOp <= ctrlPkg::aluAdd;
			srcB <= ctrlPkg::srcReg;
			regDst <= ctrlPkg::dstRd;
			amtSrc <= ctrlPkg::amtShamt;
			shiftDir <= ctrlPkg::shiftHold;
		end else begin
			case (state)
				ctrlPkg::stFetch: state <= ctrlPkg::stDecode;
				ctrlPkg::stDecode: begin
					srcB <= ctrlPkg::srcReg;
					regDst <= ctrlPkg::dstRd;
					amtSrc <= ctrlPkg::amtShamt;
					state <= ctrlPkg::stFetch; // unknown encoding, no-op
					case (opcode)
						isaPkg::ARIT: begin
							case (funct)
								isaPkg::ADD: begin
									aluOp <= ctrlPkg::aluAdd;
									state <= ctrlPkg::stAluExec;
								end
								isaPkg::SUB: begin
									aluOp <= ctrlPkg::aluSub;
									state <= ctrlPkg::stAluExec;
								end
								isaPkg::AND: begin
									aluOp <= ctrlPkg::aluAnd;
									state <= ctrlPkg::stAluExec;
								end
								isaPkg::SLT: begin
									aluOp <= ctrlPkg::aluSlt;
									state <= ctrlPkg::stAluExec;
								end
								isaPkg::SLL: begin
									shiftDir <= ctrlPkg::shiftLeft;
									state <= ctrlPkg::stShiftLoad;
								end
								isaPkg::SRL: begin
									shiftDir <= ctrlPkg::shiftRightLogic;
									state <= ctrlPkg::stShiftLoad;
								end
								isaPkg::SRA: begin
									shiftDir <= ctrlPkg::shiftRightArith;
									state <= ctrlPkg::stShiftLoad;
								end
								isaPkg::SLLV: begin
									shiftDir <= ctrlPkg::shiftLeft;
									amtSrc <= ctrlPkg::amtReg;
									state <= ctrlPkg::stShiftLoad;
								end
								isaPkg::SRAV: begin
									shiftDir <= ctrlPkg::shiftRightArith;
									amtSrc <= ctrlPkg::amtReg;
									state <= ctrlPkg::stShiftLoad;
								end
								isaPkg::JR: state <= ctrlPkg::stJump;
								default: ;
							endcase
						end
						isaPkg::ADDI, isaPkg::ADDIU: begin // both wrap, no trap
							aluOp <= ctrlPkg::aluAdd;
							srcB <= ctrlPkg::srcImm;
							regDst <= ctrlPkg::dstRt;
							state <= ctrlPkg::stAluExec;
						end
						default: ;
					endcase
				end
				ctrlPkg::stAluExec: state <= ctrlPkg::stAluWrite;
				ctrlPkg::stAluWrite: state <= ctrlPkg::stFetch;
				ctrlPkg::stShiftLoad: state <= ctrlPkg::stShiftRun;
				ctrlPkg::stShiftRun: state <= ctrlPkg::stShiftWrite;
				ctrlPkg::stShiftWrite: state <= ctrlPkg::stFetch;
				ctrlPkg::stJump: state <= ctrlPkg::stFetch;
				default: state <= ctrlPkg::stFetch;
			endcase
		end
	end

	assign instrRead = (state == ctrlPkg::stFetch);
	assign irLoad = (state == ctrlPkg::stFetch);
	assign pcLoad = (state == ctrlPkg::stFetch) || (state == ctrlPkg::stJump);
	assign pcSrc = (state == ctrlPkg::stJump) ? ctrlPkg::pcReg : ctrlPkg::pcSeq;
	assign operandLoad = (state == ctrlPkg::stDecode);
	assign aluOutLoad = (state == ctrlPkg::stAluExec);
	assign regWrite = (state == ctrlPkg::stAluWrite) || (state == ctrlPkg::stShiftWrite);
	assign wbSrc = (state == ctrlPkg::stShiftWrite) ? ctrlPkg::wbShift : ctrlPkg::wbAlu;

	always_comb begin
		case (state)
			ctrlPkg::stShiftLoad: shiftOp = ctrlPkg::shiftLoad; // take B
			ctrlPkg::stShiftRun: shiftOp = shiftDir;
			default: shiftOp = ctrlPkg::shiftHold;
		endcase
	end

	noWriteOnFetch: assert property (@(posedge clk) disable iff (reset)
		!(regWrite && instrRead));

	legalState: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(state) && state inside {ctrlPkg::stFetch, ctrlPkg::stDecode,
		ctrlPkg::stAluExec, ctrlPkg::stAluWrite, ctrlPkg::stShiftLoad,
		ctrlPkg::stShiftRun, ctrlPkg::stShiftWrite, ctrlPkg::stJump});

endmodule

`default_nettype wire

// File: fetchUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fetchUnit #(
	parameter logic [isaPkg::wordWidth-1:0] resetPc = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [isaPkg::wordWidth-1:0] instr,
	input wire logic irLoad,
	input wire logic pcLoad,
	input wire ctrlPkg::pcSrc_t pcSrc,
	input wire logic [isaPkg::wordWidth-1:0] jumpTarget,
	output logic [isaPkg::wordWidth-1:0] instrAddr,
	output isaPkg::opcode_t opcode,
	output isaPkg::funct_t funct,
	output logic [isaPkg::regAddrWidth-1:0] rs,
	output logic [isaPkg::regAddrWidth-1:0] rt,
	output logic [isaPkg::regAddrWidth-1:0] rd,
	output logic [isaPkg::shamtWidth-1:0] shamt,
	output logic [isaPkg::immWidth-1:0] imm
);

	logic [isaPkg::wordWidth-1:0] pc;
	logic [isaPkg::wordWidth-1:0] ir;
	logic [isaPkg::wordWidth-1:0] nextPc;

	assign nextPc = (pcSrc == ctrlPkg::pcReg) ? jumpTarget : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			ir <= '0;
		end else begin
			if (pcLoad) pc <= nextPc;
			if (irLoad) ir <= instr;
		end
	end

	assign instrAddr = pc;

	// standard MIPS field layout
	assign opcode = isaPkg::opcode_t'(ir[31:26]);
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign shamt = ir[10:6];
	assign funct = isaPkg::funct_t'(ir[5:0]);
	assign imm = ir[15:0];

	pcHold: assert property (@(posedge clk) disable iff (reset) !pcLoad |=> $stable(pc));

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic reset,
	input wire logic [isaPkg::regAddrWidth-1:0] rs,
	input wire logic [isaPkg::regAddrWidth-1:0] rt,
	input wire logic [isaPkg::regAddrWidth-1:0] rd,
	input wire logic operandLoad,
	input wire logic regWrite,
	input wire ctrlPkg::regDst_t regDst,
	input wire ctrlPkg::wbSrc_t wbSrc,
	input wire logic [isaPkg::wordWidth-1:0] aluResult,
	input wire logic [isaPkg::wordWidth-1:0] shiftResult,
	output logic [isaPkg::wordWidth-1:0] operandA,
	output logic [isaPkg::wordWidth-1:0] operandB,
	output logic regWriteEn,
	output logic [isaPkg::regAddrWidth-1:0] regWriteAddr,
	output logic [isaPkg::wordWidth-1:0] regWriteData
);

	logic [isaPkg::wordWidth-1:0] regs [2**isaPkg::regAddrWidth];

	assign regWriteEn = regWrite;
	assign regWriteAddr = (regDst == ctrlPkg::dstRt) ? rt : rd;
	assign regWriteData = (wbSrc == ctrlPkg::wbShift) ? shiftResult : aluResult;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**isaPkg::regAddrWidth; i++) regs[i] <= '0;
			operandA <= '0;
			operandB <= '0;
		end else begin
			if (regWrite && regWriteAddr != '0) regs[regWriteAddr] <= regWriteData; // r0 not stored
			if (operandLoad) begin
				operandA <= regs[rs];
				operandB <= regs[rt];
			end
		end
	end

	zeroReg: assert property (@(posedge clk) disable iff (reset)
		operandLoad && rs == '0 |=> operandA == '0);

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input wire logic clk,
	input wire logic reset,
	input wire logic [isaPkg::wordWidth-1:0] operandA,
	input wire logic [isaPkg::wordWidth-1:0] operandB,
	input wire logic [isaPkg::immWidth-1:0] imm,
	input wire ctrlPkg::srcB_t srcB,
	input wire ctrlPkg::aluOp_t aluOp,
	input wire logic aluOutLoad,
	output logic [isaPkg::wordWidth-1:0] aluResult
);

	logic [isaPkg::wordWidth-1:0] immExt;
	logic [isaPkg::wordWidth-1:0] b;
	logic [isaPkg::wordWidth-1:0] result;

	assign immExt = {{(isaPkg::wordWidth-isaPkg::immWidth){imm[isaPkg::immWidth-1]}}, imm};
	assign b = (srcB == ctrlPkg::srcImm) ? immExt : operandB;

	always_comb begin
		case (aluOp)
			ctrlPkg::aluAdd: result = operandA + b; // wraps
			ctrlPkg::aluSub: result = operandA - b;
			ctrlPkg::aluAnd: result = operandA & b;
			ctrlPkg::aluSlt: result = {{(isaPkg::wordWidth-1){1'b0}},
				($signed(operandA) < $signed(b))};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) aluResult <= '0;
		else if (aluOutLoad) aluResult <= result;
	end

endmodule

`default_nettype wire

// File: shifter.sv
`timescale 1ns/10ps
`default_nettype none

module shifter (
	input wire logic clk,
	input wire logic reset,
	input wire logic [isaPkg::wordWidth-1:0] operandA,
	input wire logic [isaPkg::wordWidth-1:0] operandB,
	input wire logic [isaPkg::shamtWidth-1:0] shamt,
	input wire ctrlPkg::shiftOp_t shiftOp,
	input wire ctrlPkg::amtSrc_t amtSrc,
	output logic [isaPkg::wordWidth-1:0] shiftResult
);

	logic [isaPkg::wordWidth-1:0] held;
	logic [isaPkg::shamtWidth-1:0] amount;

	// variable shifts take rs[4:0]
	assign amount = (amtSrc == ctrlPkg::amtReg) ? operandA[isaPkg::shamtWidth-1:0] : shamt;

	always_ff @(posedge clk) begin
		if (reset) begin
			held <= '0;
		end else begin
			case (shiftOp)
				ctrlPkg::shiftLoad: held <= operandB; // rt value
				ctrlPkg::shiftLeft: held <= held << amount;
				ctrlPkg::shiftRightLogic: held <= held >> amount;
				ctrlPkg::shiftRightArith: held <= $unsigned($signed(held) >>> amount);
				default: held <= held;
			endcase
		end
	end

	assign shiftResult = held;

endmodule

`default_nettype wire

// File: cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore #(
	parameter logic [isaPkg::wordWidth-1:0] resetPc = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [isaPkg::wordWidth-1:0] instr,
	output logic [isaPkg::wordWidth-1:0] instrAddr,
	output logic instrRead,
	output logic regWriteEn,
	output logic [isaPkg::regAddrWidth-1:0] regWriteAddr,
	output logic [isaPkg::wordWidth-1:0] regWriteData
);

	isaPkg::opcode_t opcode;
	isaPkg::funct_t funct;
	logic [isaPkg::regAddrWidth-1:0] rs;
	logic [isaPkg::regAddrWidth-1:0] rt;
	logic [isaPkg::regAddrWidth-1:0] rd;
	logic [isaPkg::shamtWidth-1:0] shamt;
	logic [isaPkg::immWidth-1:0] imm;
	logic [isaPkg::wordWidth-1:0] operandA;
	logic [isaPkg::wordWidth-1:0] operandB;
	logic [isaPkg::wordWidth-1:0] aluResult;
	logic [isaPkg::wordWidth-1:0] shiftResult;

	logic irLoad;
	logic pcLoad;
	logic operandLoad;
	logic regWrite;
	logic aluOutLoad;
	ctrlPkg::regDst_t regDst;
	ctrlPkg::wbSrc_t wbSrc;
	ctrlPkg::aluOp_t aluOp;
	ctrlPkg::srcB_t srcB;
	ctrlPkg::shiftOp_t shiftOp;
	ctrlPkg::amtSrc_t amtSrc;
	ctrlPkg::pcSrc_t pcSrc;

	controlUnit control (
		.clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
		.irLoad(irLoad), .pcLoad(pcLoad), .operandLoad(operandLoad),
		.regWrite(regWrite), .instrRead(instrRead), .aluOutLoad(aluOutLoad),
		.regDst(regDst), .wbSrc(wbSrc), .aluOp(aluOp), .srcB(srcB),
		.shiftOp(shiftOp), .amtSrc(amtSrc), .pcSrc(pcSrc)
	);

	fetchUnit #(.resetPc(resetPc)) fetch (
		.clk(clk), .reset(reset), .instr(instr), .irLoad(irLoad),
		.pcLoad(pcLoad), .pcSrc(pcSrc), .jumpTarget(operandA), // JR target
		.instrAddr(instrAddr), .opcode(opcode), .funct(funct),
		.rs(rs), .rt(rt), .rd(rd), .shamt(shamt), .imm(imm)
	);

	regFile regs (
		.clk(clk), .reset(reset), .rs(rs), .rt(rt), .rd(rd),
		.operandLoad(operandLoad), .regWrite(regWrite), .regDst(regDst),
		.wbSrc(wbSrc), .aluResult(aluResult), .shiftResult(shiftResult),
		.operandA(operandA), .operandB(operandB), .regWriteEn(regWriteEn),
		.regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
	);

	alu aluUnit (
		.clk(clk), .reset(reset), .operandA(operandA), .operandB(operandB),
		.imm(imm), .srcB(srcB), .aluOp(aluOp), .aluOutLoad(aluOutLoad),
		.aluResult(aluResult)
	);

	shifter shiftUnit (
		.clk(clk), .reset(reset), .operandA(operandA), .operandB(operandB),
		.shamt(shamt), .shiftOp(shiftOp), .amtSrc(amtSrc),
		.shiftResult(shiftResult)
	);

endmodule

`default_nettype wire

// File: cpuModel.svh
// columns of a kept encoding table, picked by genInstr
localparam int kindImm = 0;
localparam int kindAlu = 1;
localparam int kindShift = 2;
localparam int kindZero = 3;
localparam int kindMixed = 4;

logic [31:0] modelRegs [32];
logic [31:0] modelPc;

// pick: 0 JR, 1 bad funct, 2..5 ALU ops, 6 bad opcode, 7..11 shifts, 12..13 immediates
function automatic logic [31:0] genInstr(input int kind);
	logic [31:0] r;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [5:0] op;
	logic [5:0] fn;
	int pick;
	r = $urandom;
	rs = r[25:21];
	rt = r[20:16];
	op = isaPkg::ARIT;
	fn = '0;
	case (kind)
		kindImm: pick = int'($urandom_range(13, 12));
		kindAlu: pick = int'($urandom_range(5, 2));
		kindShift: pick = int'($urandom_range(11, 7));
		kindZero: begin
			pick = r[31] ? 12 : 2;
			if (r[31])
				rt = '0; // ADDI into r0
			else
				rs = '0; // ADD reading r0
		end
		default: pick = int'($urandom_range(13, 0));
	endcase
	case (pick)
		0: fn = isaPkg::JR;
		1: fn = {2'b11, r[3:0]}; // no such funct
		2: fn = isaPkg::ADD;
		3: fn = isaPkg::SUB;
		4: fn = isaPkg::AND;
		5: fn = isaPkg::SLT;
		6: op = {2'b01, r[29:26]}; // no such opcode
		7: fn = isaPkg::SLL;
		8: fn = isaPkg::SRL;
		9: fn = isaPkg::SRA;
		10: fn = isaPkg::SLLV;
		11: fn = isaPkg::SRAV;
		12: op = isaPkg::ADDI;
		default: op = isaPkg::ADDIU;
	endcase
	if (op == isaPkg::ARIT) return {op, rs, rt, r[15:6], fn};
	return {op, rs, rt, r[15:0]};
endfunction

// one instruction at ISA level, plus its expected cycle count
task automatic stepModel(input logic [31:0] word, output logic doWrite,
	output logic [4:0] dst, output logic [31:0] data, output int cycles);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] immExt;
	a = modelRegs[word[25:21]];
	b = modelRegs[word[20:16]];
	immExt = {{16{word[15]}}, word[15:0]};
	doWrite = 1'b1;
	dst = word[15:11];
	data = '0;
	cycles = 4;
	modelPc = modelPc + 32'd4;
	case (word[31:26])
		isaPkg::ADDI, isaPkg::ADDIU: begin // wrap, no trap
			dst = word[20:16];
			data = a + immExt;
		end
		isaPkg::ARIT: begin
			case (word[5:0])
				isaPkg::ADD: data = a + b;
				isaPkg::SUB: data = a - b;
				isaPkg::AND: data = a & b;
				isaPkg::SLT: data = {31'b0, $signed(a) < $signed(b)};
				isaPkg::SLL: data = b << word[10:6];
				isaPkg::SRL: data = b >> word[10:6];
				isaPkg::SRA: data = $unsigned($signed(b) >>> word[10:6]);
				isaPkg::SLLV: data = b << a[4:0];
				isaPkg::SRAV: data = $unsigned($signed(b) >>> a[4:0]);
				isaPkg::JR: begin
					doWrite = 1'b0;
					cycles = 3;
					modelPc = a;
				end
				default: begin
					doWrite = 1'b0;
					cycles = 2;
				end
			endcase
			if (word[5:0] inside {isaPkg::SLL, isaPkg::SRL, isaPkg::SRA, isaPkg::SLLV,
				isaPkg::SRAV}) cycles = 5;
		end
		default: begin
			doWrite = 1'b0;
			cycles = 2;
		end
	endcase
	if (doWrite && dst != 5'd0) modelRegs[dst] = data;
endtask

// File: cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

	localparam logic [31:0] resetPc = 32'h0000_0400;
	localparam int waitLimit = 16; // cycles per wait loop

	logic clk = 1'b0;
	logic reset;
	logic [31:0] instr;
	logic [31:0] instrAddr;
	logic instrRead;
	logic regWriteEn;
	logic [4:0] regWriteAddr;
	logic [31:0] regWriteData;

	int errorCount = 0;
	int testCount = 0;
	int instrCount = 0;
	bit timedOut = 1'b0;

	`include "cpuModel.svh"

	cpuCore #(.resetPc(resetPc)) UUT (
		.clk(clk), .reset(reset), .instr(instr), .instrAddr(instrAddr),
		.instrRead(instrRead), .regWriteEn(regWriteEn),
		.regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
	);

	always #4 clk = ~clk;

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		errorCount++;
	endtask

	task automatic printTestResult(input string name, input int count, input int startErrors);
		testCount++;
		$display("test %-6s %0d instructions, %0d errors%s", name, count,
			errorCount - startErrors, timedOut ? ", timed out" : "");
	endtask

	task automatic resetTest();
		int waited;
		int startErrors;
		startErrors = errorCount;
		foreach (modelRegs[i]) modelRegs[i] = '0;
		modelPc = resetPc;
		reset = 1'b1;
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			if (regWriteEn !== 1'b0) reportMismatch("regWriteEn", 32'(regWriteEn), 32'h0);
		end
		reset = 1'b0;
		waited = 0;
		while (!instrRead && waited < waitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (!instrRead) begin
			$display("timeout: no instruction fetch after reset");
			timedOut = 1'b1;
		end else if (instrAddr !== resetPc) begin
			reportMismatch("instrAddr", instrAddr, resetPc);
		end
		printTestResult("reset", 0, startErrors);
	endtask

	// called on a falling edge with instrRead high, returns on the next such edge
	task automatic runInstr(input int kind);
		logic [31:0] word;
		logic expWrite;
		logic [4:0] expAddr;
		logic [31:0] expData;
		int expCycles;
		int cycles;
		int writes;
		logic [4:0] gotAddr;
		logic [31:0] gotData;
		if (instrAddr !== modelPc) reportMismatch("instrAddr", instrAddr, modelPc);
		word = genInstr(kind);
		instr = word;
		stepModel(word, expWrite, expAddr, expData, expCycles);
		instrCount++;
		cycles = 0;
		writes = 0;
		gotAddr = '0;
		gotData = '0;
		do begin
			@(negedge clk);
			cycles++;
			if (regWriteEn === 1'b1) begin
				writes++;
				gotAddr = regWriteAddr;
				gotData = regWriteData;
			end
		end while (!instrRead && cycles < waitLimit);
		if (!instrRead) begin
			$display("timeout: no instruction fetch after instruction %h", word);
			timedOut = 1'b1;
			return;
		end
		if (cycles != expCycles) reportMismatch("cycles", 32'(cycles), 32'(expCycles));
		if (writes != (expWrite ? 1 : 0))
			reportMismatch("regWriteEn pulses", 32'(writes), expWrite ? 32'h1 : 32'h0);
		if (expWrite && writes == 1) begin
			if (gotAddr !== expAddr) reportMismatch("regWriteAddr", 32'(gotAddr), 32'(expAddr));
			if (gotData !== expData) reportMismatch("regWriteData", gotData, expData);
		end
	endtask

	task automatic runTest(input string name, input int kind, input int count);
		int startErrors;
		int done;
		startErrors = errorCount;
		done = 0;
		while (done < count && !timedOut) begin
			runInstr(kind);
			done++;
		end
		printTestResult(name, done, startErrors);
	endtask

	initial begin
		void'($urandom(56));
		reset = 1'b1;
		instr = '0;
		resetTest();
		runTest("addi", kindImm, 40); // also fills registers
		runTest("alu", kindAlu, 60);
		runTest("shift", kindShift, 60);
		runTest("zero", kindZero, 30);
		runTest("mixed", kindMixed, 150); // JR and bad encodings
		$display("tests %0d, instructions %0d, errors %0d, timeouts %0d",
			testCount, instrCount, errorCount, timedOut);
		if (errorCount == 0 && !timedOut) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
controlUnit.sv
fetchUnit.sv
regFile.sv
alu.sv
shifter.sv
cpuCore.sv
cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST ?= sim.f
TOP ?= cpuTb
RTL_TOP ?= cpuCore
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG ?= Simulation PASSED

.PHONY: run build lint clean

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
